/* rtl/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    // ############################
    // widths
    // ############################

    // register index.
    typedef logic [4:0] reg_addr_t;

    // register data.
    typedef logic [31:0] word_t;

    // pc and branch targets.
    typedef logic [31:0] inst_addr_t;

    // byte address into data memory.
    typedef logic [31:0] data_addr_t;

    // ############################
    // operations
    // ############################

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,
        // shifts take rs2[4:0] as the amount.
        SLL = 4'd6,
        SRL = 4'd7,
        BEQ = 4'd8,
        BNE = 4'd9,
        // word accesses only.
        LW  = 4'd10,
        SW  = 4'd11,
        NOP = 4'd12
    } cmd_t;

endpackage

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import riscv_isa_pkg::*;

    // one operation as issued, operands already read.
    typedef struct packed {
        cmd_t       cmd;
        inst_addr_t pc;
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        reg_addr_t  rd;
    } issue_t;

    // EX/MEM payload. store data rides in rsd_data.
    typedef struct packed {
        cmd_t       cmdtype;
        reg_addr_t  rsd_addr;
        word_t      rsd_data;
        logic       write_rsd;
        logic       branch;
        inst_addr_t branch_address;
        data_addr_t mem_addr;
        logic       mem_read;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // one bit per stage, bit 0 is the front.
    typedef logic [5:0] stall_t;

    localparam int STALL_EX  = 3;
    localparam int STALL_MEM = 4;

endpackage

`default_nettype wire

/* rtl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import riscv_isa_pkg::*, pipe_pkg::*; (
    input  logic    clk_in,
    input  logic    reset,
    input  stall_t  stall,
    input  issue_t  issue,
    input  logic    issue_strobe,
    output ex_mem_t ex_out,
    output logic    ex_stall_req
);

    logic       valid;
    logic       shifting;
    logic [4:0] count;
    cmd_t       cmd;
    inst_addr_t pc;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;
    reg_addr_t  rd;
    word_t      result;
    logic       take;
    logic       step;
    logic       frozen;
    logic       taken;

    // all bits set only when rdy_in is low.
    assign frozen = &stall;
    assign take   = issue_strobe && !stall[STALL_EX];
    assign step   = shifting && !frozen && (count != '0);

    assign ex_stall_req = shifting;

    // ############################
    // control
    // ############################

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid    <= 1'b0;
            shifting <= 1'b0;
            count    <= '0;
        end else begin
            // one idle step at count zero marks the last cycle.
            if (shifting && !frozen && count == '0) begin
                shifting <= 1'b0;
            end
            if (step) begin
                count <= count - 1'b1;
            end
            if (!stall[STALL_EX]) begin
                valid <= issue_strobe;
                if (issue_strobe) begin
                    shifting <= issue.cmd inside {SLL, SRL};
                    count    <= issue.rs2[4:0];
                end
            end
        end
    end

    // working registers.
    always_ff @(posedge clk_in) begin
        if (take) begin
            cmd  <= issue.cmd;
            pc   <= issue.pc;
            op_a <= issue.rs1;
            op_b <= issue.rs2;
            imm  <= issue.imm;
            rd   <= issue.rd;
        end else if (step) begin
            op_a <= (cmd == SLL) ? (op_a << 1) : (op_a >> 1);
        end
    end

    // ############################
    // result
    // ############################

    always_comb begin
        case (cmd)
            ADD:      result = op_a + op_b;
            SUB:      result = op_a - op_b;
            AND:      result = op_a & op_b;
            OR:       result = op_a | op_b;
            XOR:      result = op_a ^ op_b;
            SLT:      result = word_t'($signed(op_a) < $signed(op_b));
            SLL, SRL: result = op_a;
            SW:       result = op_b;
            default:  result = '0;
        endcase
    end

    assign taken = (cmd == BEQ && op_a == op_b) || (cmd == BNE && op_a != op_b);

    always_comb begin
        ex_out.cmdtype        = valid ? cmd : NOP;
        ex_out.rsd_addr       = rd;
        ex_out.rsd_data       = result;
        ex_out.write_rsd      = valid && (cmd inside {ADD, SUB, AND, OR, XOR, SLT,
                                                      SLL, SRL, LW});
        ex_out.branch         = valid && taken;
        ex_out.branch_address = pc + imm;
        ex_out.mem_addr       = op_a + imm;
        ex_out.mem_read       = valid && (cmd == LW);
    end

    // a stall request always belongs to a captured shift.
    assert property (@(posedge clk_in) disable iff (reset)
        ex_stall_req |-> valid && (cmd inside {SLL, SRL}));

endmodule

`default_nettype wire

/* rtl/ex_mem_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg import riscv_isa_pkg::*, pipe_pkg::*; (
    input  logic    clk_in,
    input  logic    reset,
    input  logic    rdy_in,
    input  stall_t  stall,
    input  ex_mem_t ex_out,
    output ex_mem_t mem_in
);

    localparam ex_mem_t BUBBLE = '{
        cmdtype:        NOP,
        rsd_addr:       '0,
        rsd_data:       '0,
        write_rsd:      1'b0,
        branch:         1'b0,
        branch_address: '0,
        mem_addr:       '0,
        mem_read:       1'b0
    };

    // ############################
    // pipeline register
    // ############################

    always_ff @(posedge clk_in) begin
        if (reset) begin
            // cmdtype follows execute even in reset.
            mem_in         <= BUBBLE;
            mem_in.cmdtype <= ex_out.cmdtype;
        end else if (stall[STALL_EX] && !stall[STALL_MEM]) begin
            // execute stalled alone.
            mem_in <= BUBBLE;
        end else if (!stall[STALL_EX] && rdy_in) begin
            mem_in <= ex_out;
        end
    end

    // held operation survives any memory stall untouched.
    assert property (@(posedge clk_in) disable iff (reset)
        stall[STALL_MEM] |=> $stable(mem_in));

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import riscv_isa_pkg::*, pipe_pkg::*; #(
    parameter int DMEM_WORDS = 16
) (
    input  logic       clk_in,
    input  logic       reset,
    input  stall_t     stall,
    input  ex_mem_t    mem_in,
    output logic       mem_stall_req,
    output wb_t        wb,
    output logic       wb_strobe,
    output logic       branch_taken,
    output inst_addr_t branch_target
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    typedef enum logic {
        IDLE,
        LOAD_WAIT
    } state_t;

    state_t           state;
    word_t            dmem [DMEM_WORDS];
    word_t            load_data;
    logic [IDX_W-1:0] idx;
    logic             frozen;
    logic             retire;

    assign frozen = &stall;
    // word index.
    assign idx    = mem_in.mem_addr[IDX_W+1:2];

    assign mem_stall_req = (state == IDLE) && mem_in.mem_read;
    assign retire        = !frozen && ((state == IDLE && !mem_in.mem_read) ||
                                       state == LOAD_WAIT);

    // ############################
    // load wait fsm
    // ############################

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
        end else if (!frozen) begin
            case (state)
                IDLE: begin
                    if (mem_in.mem_read) begin
                        state <= LOAD_WAIT;
                    end
                end
                LOAD_WAIT: state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // data memory, read registered.
    always_ff @(posedge clk_in) begin
        if (retire && mem_in.cmdtype == SW) begin
            dmem[idx] <= mem_in.rsd_data;
        end
        if (!frozen && state == IDLE && mem_in.mem_read) begin
            load_data <= dmem[idx];
        end
    end

    // ############################
    // writeback and branch
    // ############################

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wb_strobe    <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            wb_strobe    <= retire && mem_in.write_rsd;
            branch_taken <= retire && mem_in.branch;
        end
    end

    always_ff @(posedge clk_in) begin
        if (retire) begin
            wb.rd         <= mem_in.rsd_addr;
            wb.data       <= mem_in.mem_read ? load_data : mem_in.rsd_data;
            branch_target <= mem_in.branch_address;
        end
    end

    assert property (@(posedge clk_in) disable iff (reset)
        !(wb_strobe && branch_taken));

endmodule

`default_nettype wire

/* rtl/stall_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stall_ctrl import pipe_pkg::*; (
    input  logic   rdy_in,
    input  logic   ex_stall_req,
    input  logic   mem_stall_req,
    output stall_t stall
);

    // ############################
    // priority encoder
    // ############################

    // a stage stalls itself and everything in front of it.
    // rdy_in low freezes every stage.
    always_comb begin
        stall = '0;
        for (int i = 0; i < $bits(stall_t); i++) begin
            if (!rdy_in) begin
                stall[i] = 1'b1;
            end else if (mem_stall_req && i <= STALL_MEM) begin
                stall[i] = 1'b1;
            end else if (ex_stall_req && i <= STALL_EX) begin
                stall[i] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ex_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_top import riscv_isa_pkg::*, pipe_pkg::*; #(
    parameter int DMEM_WORDS = 16
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rdy_in,
    input  issue_t     issue,
    input  logic       issue_strobe,
    output logic       ex_busy,
    output wb_t        wb,
    output logic       wb_strobe,
    output logic       branch_taken,
    output inst_addr_t branch_target
);

    ex_mem_t ex_out;
    ex_mem_t mem_in;
    stall_t  stall;
    logic    ex_stall_req;
    logic    mem_stall_req;

    // issue is accepted only with execute free.
    assign ex_busy = stall[STALL_EX];

    ex_stage ex_stage_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .stall        (stall),
        .issue        (issue),
        .issue_strobe (issue_strobe),
        .ex_out       (ex_out),
        .ex_stall_req (ex_stall_req)
    );

    ex_mem_reg ex_mem_reg_i (
        .clk_in (clk_in),
        .reset  (reset),
        .rdy_in (rdy_in),
        .stall  (stall),
        .ex_out (ex_out),
        .mem_in (mem_in)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mem_stage_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .stall         (stall),
        .mem_in        (mem_in),
        .mem_stall_req (mem_stall_req),
        .wb            (wb),
        .wb_strobe     (wb_strobe),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    stall_ctrl stall_ctrl_i (
        .rdy_in        (rdy_in),
        .ex_stall_req  (ex_stall_req),
        .mem_stall_req (mem_stall_req),
        .stall         (stall)
    );

endmodule

`default_nettype wire

/* verif/tb_ex_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_mem import riscv_isa_pkg::*, pipe_pkg::*; ();

    localparam int DMEM_WORDS = 16;
    localparam int IDX_W      = $clog2(DMEM_WORDS);
    localparam int N_ISSUES   = 300;
    localparam int N_CLEAN    = 60;
    // fill stores and the load burst come on top.
    localparam int LIMIT      = (N_ISSUES + DMEM_WORDS + 4) * 12 + 200;

    typedef struct packed {
        logic        is_branch;
        wb_t         wb;
        inst_addr_t  target;
        logic        clean;
        logic [31:0] due;
    } expect_t;

    logic       clk_in;
    logic       reset;
    logic       rdy_in;
    issue_t     issue;
    logic       issue_strobe;
    logic       ex_busy;
    wb_t        wb;
    logic       wb_strobe;
    logic       branch_taken;
    inst_addr_t branch_target;

    expect_t exp_q [$];
    word_t   mem_model [DMEM_WORDS];
    int      cycle       = 0;
    int      last_slot   = 0;
    logic    clean_phase = 1'b1;
    logic    rdy_drops   = 1'b0;

    ex_mem_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) ex_mem_top_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .rdy_in        (rdy_in),
        .issue         (issue),
        .issue_strobe  (issue_strobe),
        .ex_busy       (ex_busy),
        .wb            (wb),
        .wb_strobe     (wb_strobe),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // ############################
    // clock and watchdog
    // ############################

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("timeout after %0d cycles, results stopped arriving", cycle);
            abort_run();
        end
    end

    // random stretches of rdy_in low.
    initial begin : rdy_driver
        int hold;
        hold   = 0;
        rdy_in = 1'b1;
        forever begin
            @(posedge clk_in);
            #2;
            if (hold > 0) begin
                hold   = hold - 1;
                rdy_in = (hold == 0);
            end else if (rdy_drops && $urandom_range(0, 7) == 0) begin
                hold   = $urandom_range(1, 6);
                rdy_in = 1'b0;
            end
        end
    end

    // ############################
    // reference model
    // ############################

    function automatic logic expected_result(input issue_t op, output expect_t e);
        word_t            addr;
        logic [IDX_W-1:0] widx;
        logic             has;
        addr    = op.rs1 + op.imm;
        widx    = addr[IDX_W+1:2];
        e       = '0;
        e.wb.rd = op.rd;
        has     = 1'b1;
        case (op.cmd)
            ADD:     e.wb.data = op.rs1 + op.rs2;
            SUB:     e.wb.data = op.rs1 - op.rs2;
            AND:     e.wb.data = op.rs1 & op.rs2;
            OR:      e.wb.data = op.rs1 | op.rs2;
            XOR:     e.wb.data = op.rs1 ^ op.rs2;
            SLT:     e.wb.data = ($signed(op.rs1) < $signed(op.rs2)) ? 32'd1 : 32'd0;
            SLL:     e.wb.data = op.rs1 << op.rs2[4:0];
            SRL:     e.wb.data = op.rs1 >> op.rs2[4:0];
            LW:      e.wb.data = mem_model[widx];
            SW: begin
                mem_model[widx] = op.rs2;
                has = 1'b0;
            end
            BEQ, BNE: begin
                e.is_branch = 1'b1;
                e.target    = op.pc + op.imm;
                has         = (op.rs1 == op.rs2) == (op.cmd == BEQ);
            end
            default: has = 1'b0;
        endcase
        return has;
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hA5C3_0F69;
    endfunction

    // ############################
    // checks
    // ############################

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: writeback x%0d = %h, expected x%0d = %h",
                     $time, got.rd, got.data, exp.rd, exp.data);
            abort_run();
        end
    endtask

    task automatic check_branch(input inst_addr_t got, input inst_addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: branch target %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL at %0t: %s was %0d cycles, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ############################
    // stimulus
    // ############################

    task automatic next_slot();
        @(posedge clk_in);
        #2;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            next_slot();
        end
    endtask

    function automatic issue_t mem_op(input cmd_t cmd, input int slot, input word_t data);
        issue_t op;
        op     = '0;
        op.cmd = cmd;
        op.rs1 = 4 * slot;
        op.rs2 = data;
        op.rd  = reg_addr_t'(slot + 1);
        return op;
    endfunction

    function automatic issue_t random_op();
        issue_t op;
        int     slot;
        op.cmd = cmd_t'($urandom_range(0, 12));
        op.pc  = $urandom & 32'hFFFF_FFFC;
        op.rs1 = $urandom;
        op.rs2 = $urandom;
        op.imm = $urandom;
        op.rd  = reg_addr_t'($urandom_range(0, 31));
        case (op.cmd)
            SLL, SRL: op.rs2 = $urandom_range(0, 7);
            BEQ, BNE: begin
                if ($urandom_range(0, 1) == 1) begin
                    op.rs2 = op.rs1;
                end
            end
            LW, SW: begin
                // often reuse the last stored word.
                slot = ($urandom_range(0, 3) == 0) ? last_slot
                                                   : $urandom_range(0, DMEM_WORDS - 1);
                if (op.cmd == SW) begin
                    last_slot = slot;
                end
                op.rs1 = 4 * $urandom_range(0, DMEM_WORDS - 1);
                op.imm = 4 * slot - op.rs1;
            end
            default: ;
        endcase
        return op;
    endfunction

    // holds the issue until an edge with ex_busy low takes it.
    task automatic send_op(input issue_t op);
        expect_t e;
        logic    accepted;
        int      lat;
        issue        = op;
        issue_strobe = 1'b1;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk_in);
            accepted = !ex_busy;
            @(posedge clk_in);
        end
        #2;
        issue_strobe = 1'b0;
        lat = 2;
        if (op.cmd inside {SLL, SRL}) begin
            lat = lat + int'(op.rs2[4:0]) + 1;
        end
        if (op.cmd == LW) begin
            lat = lat + 1;
        end
        if (expected_result(op, e)) begin
            e.clean = clean_phase;
            e.due   = cycle + lat;
            exp_q.push_back(e);
        end
    endtask

    initial begin : stimulus
        issue_t op;
        int     busy;
        void'($urandom(67229));
        reset        = 1'b1;
        issue_strobe = 1'b0;
        issue        = '0;
        repeat (5) @(posedge clk_in);
        #2;
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk_in);
            if (wb_strobe || branch_taken || ex_busy) begin
                $display("outputs went active after reset before any issue");
                abort_run();
            end
        end
        next_slot();
        for (int w = 0; w < DMEM_WORDS; w++) begin
            send_op(mem_op(SW, w, fill_word(4 * w)));
        end
        // one operation in flight at a time.
        for (int n = 0; n < N_CLEAN; n++) begin
            wait_drained();
            op = random_op();
            send_op(op);
            if (op.cmd inside {SLL, SRL}) begin
                busy = 0;
                @(negedge clk_in);
                while (ex_busy) begin
                    busy++;
                    @(negedge clk_in);
                end
                check_cycles("shift busy", busy, int'(op.rs2[4:0]) + 1);
                next_slot();
            end
        end
        clean_phase = 1'b0;
        send_op(mem_op(SW, 5, 32'h1357_9BDF));
        send_op(mem_op(LW, 5, '0));
        send_op(mem_op(LW, 5, '0));
        send_op(mem_op(LW, 9, '0));
        rdy_drops = 1'b1;
        for (int n = N_CLEAN; n < N_ISSUES; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                next_slot();
            end
            send_op(random_op());
        end
        rdy_drops = 1'b0;
        wait_drained();
        // stray results would show up here.
        repeat (20) next_slot();
        $display("RESULT: PASS");
        $finish;
    end

    // ############################
    // compare
    // ############################

    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk_in);
            if (wb_strobe || branch_taken) begin
                if (exp_q.size() == 0) begin
                    $display("a result arrived at %0t with nothing outstanding", $time);
                    abort_run();
                end
                e = exp_q.pop_front();
                if (e.is_branch) begin
                    if (wb_strobe) begin
                        $display("a writeback arrived where a branch was expected");
                        abort_run();
                    end
                    check_branch(branch_target, e.target);
                end else begin
                    if (branch_taken) begin
                        $display("a branch pulse arrived where a writeback was expected");
                        abort_run();
                    end
                    check_wb(wb, e.wb);
                end
                if (e.clean) begin
                    check_cycles("result latency", cycle - (int'(e.due) - 2), 2);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/riscv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/ex_stage.sv
rtl/ex_mem_reg.sv
rtl/mem_stage.sv
rtl/stall_ctrl.sv
rtl/ex_mem_top.sv
verif/tb_ex_mem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EX/MEM testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_ex_mem \
    -Mdir obj_dir \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ex_mem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
